//--- Bender.yml
package:
  name: cache_axi_wb

sources:
  - include_dirs:
      - src
    files:
      - src/cache_axi_pkg.sv
      - src/tag_fifo.sv
      - src/word_packer.sv
      - src/writeback_arbiter.sv
      - src/cache_to_axi_tx.sv
      - src/cache_axi_wb_top.sv
      - target: test
        files:
          - tb/tb_cache_axi_wb.sv

//--- sources.f
+incdir+src
src/cache_axi_pkg.sv
src/tag_fifo.sv
src/word_packer.sv
src/writeback_arbiter.sv
src/cache_to_axi_tx.sv
src/cache_axi_wb_top.sv
tb/tb_cache_axi_wb.sv

//--- src/cache_axi_pkg.sv
// Cache write-back types
`include "cache_axi_settings.svh"

package cache_axi_pkg;

  // cache index, also the tag queued between address and data
  typedef logic [$clog2(`CA_NUM_CACHE)-1:0] cache_tag_t;

  typedef logic [`CA_DATA_WIDTH-1:0]     dma_word_t;
  typedef logic [`CA_AXI_DATA_WIDTH-1:0] axi_beat_t;
  typedef logic [`CA_AXI_ADDR_WIDTH-1:0] axi_addr_t;

  // counters within one block
  typedef logic [$clog2(`CA_AXI_BURST_LEN)-1:0] beat_cnt_t;
  typedef logic [$clog2(`CA_BLOCK_WORDS)-1:0]   word_cnt_t;

  // awburst encoding
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic {
    ARB_IDLE  = 1'b0,
    ARB_OFFER = 1'b1  // awvalid up, choice frozen
  } arb_state_e;

endpackage

//--- src/cache_axi_settings.svh
// Cache write-back sizes
`ifndef CACHE_AXI_SETTINGS_SVH
`define CACHE_AXI_SETTINGS_SVH

// cache side
`define CA_NUM_CACHE      4
`define CA_DATA_WIDTH     32   // dma word
`define CA_BLOCK_WORDS    8    // words per cache block

// axi side
`define CA_AXI_DATA_WIDTH 64
`define CA_AXI_ADDR_WIDTH 32
`define CA_AXI_ID_WIDTH   4

// beats per burst, one burst per block:
// block words / (axi width / word width)
`define CA_AXI_BURST_LEN  4

`endif

//--- src/cache_axi_wb_top.sv
// Cache write-back to AXI top
`timescale 1ns/1ps
`include "cache_axi_settings.svh"

module cache_axi_wb_top
  import cache_axi_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  // write-back requests
  input  logic      [`CA_NUM_CACHE-1:0]       wb_v_i,
  input  axi_addr_t [`CA_NUM_CACHE-1:0]       wb_addr_i,
  output logic      [`CA_NUM_CACHE-1:0]       wb_yumi_o,

  // dma words
  input  dma_word_t [`CA_NUM_CACHE-1:0]       dma_data_i,
  input  logic      [`CA_NUM_CACHE-1:0]       dma_data_v_i,
  output logic      [`CA_NUM_CACHE-1:0]       dma_data_yumi_o,

  output logic [`CA_AXI_ID_WIDTH-1:0]         axi_awid_o,
  output axi_addr_t                           axi_awaddr_o,
  output logic [7:0]                          axi_awlen_o,
  output logic [2:0]                          axi_awsize_o,
  output axi_burst_e                          axi_awburst_o,
  output logic [3:0]                          axi_awcache_o,
  output logic [2:0]                          axi_awprot_o,
  output logic                                axi_awlock_o,
  output logic                                axi_awvalid_o,
  input  logic                                axi_awready_i,

  output axi_beat_t                           axi_wdata_o,
  output logic [`CA_AXI_DATA_WIDTH/8-1:0]     axi_wstrb_o,
  output logic                                axi_wlast_o,
  output logic                                axi_wvalid_o,
  input  logic                                axi_wready_i,

  input  logic [`CA_AXI_ID_WIDTH-1:0]         axi_bid_i,
  input  logic [1:0]                          axi_bresp_i,
  input  logic                                axi_bvalid_i,
  output logic                                axi_bready_o
);

  logic       req_v;
  cache_tag_t req_tag;
  axi_addr_t  req_addr;
  logic       req_yumi;   // aw handshake

  writeback_arbiter u_arb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wb_v_i     (wb_v_i),
    .wb_addr_i  (wb_addr_i),
    .wb_yumi_o  (wb_yumi_o),
    .req_v_o    (req_v),
    .req_tag_o  (req_tag),
    .req_addr_o (req_addr),
    .req_yumi_i (req_yumi)
  );

  cache_to_axi_tx u_tx (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .v_i             (req_v),
    .yumi_o          (req_yumi),
    .tag_i           (req_tag),
    .axi_addr_i      (req_addr),
    .dma_data_i      (dma_data_i),
    .dma_data_v_i    (dma_data_v_i),
    .dma_data_yumi_o (dma_data_yumi_o),
    .axi_awid_o      (axi_awid_o),
    .axi_awaddr_o    (axi_awaddr_o),
    .axi_awlen_o     (axi_awlen_o),
    .axi_awsize_o    (axi_awsize_o),
    .axi_awburst_o   (axi_awburst_o),
    .axi_awcache_o   (axi_awcache_o),
    .axi_awprot_o    (axi_awprot_o),
    .axi_awlock_o    (axi_awlock_o),
    .axi_awvalid_o   (axi_awvalid_o),
    .axi_awready_i   (axi_awready_i),
    .axi_wdata_o     (axi_wdata_o),
    .axi_wstrb_o     (axi_wstrb_o),
    .axi_wlast_o     (axi_wlast_o),
    .axi_wvalid_o    (axi_wvalid_o),
    .axi_wready_i    (axi_wready_i),
    .axi_bid_i       (axi_bid_i),
    .axi_bresp_i     (axi_bresp_i),
    .axi_bvalid_i    (axi_bvalid_i),
    .axi_bready_o    (axi_bready_o)
  );

endmodule

//--- src/cache_to_axi_tx.sv
// AXI write channel driver
`timescale 1ns/1ps
`include "cache_axi_settings.svh"

module cache_to_axi_tx
  import cache_axi_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  input  logic                                v_i,
  output logic                                yumi_o,
  input  cache_tag_t                          tag_i,
  input  axi_addr_t                           axi_addr_i,

  // cache dma words
  input  dma_word_t [`CA_NUM_CACHE-1:0]       dma_data_i,
  input  logic      [`CA_NUM_CACHE-1:0]       dma_data_v_i,
  output logic      [`CA_NUM_CACHE-1:0]       dma_data_yumi_o,

  // write address
  output logic [`CA_AXI_ID_WIDTH-1:0]         axi_awid_o,
  output axi_addr_t                           axi_awaddr_o,
  output logic [7:0]                          axi_awlen_o,
  output logic [2:0]                          axi_awsize_o,
  output axi_burst_e                          axi_awburst_o,
  output logic [3:0]                          axi_awcache_o,
  output logic [2:0]                          axi_awprot_o,
  output logic                                axi_awlock_o,
  output logic                                axi_awvalid_o,
  input  logic                                axi_awready_i,

  // write data
  output axi_beat_t                           axi_wdata_o,
  output logic [`CA_AXI_DATA_WIDTH/8-1:0]     axi_wstrb_o,
  output logic                                axi_wlast_o,
  output logic                                axi_wvalid_o,
  input  logic                                axi_wready_i,

  // write response
  input  logic [`CA_AXI_ID_WIDTH-1:0]         axi_bid_i,
  input  logic [1:0]                          axi_bresp_i,
  input  logic                                axi_bvalid_i,
  output logic                                axi_bready_o
);

  localparam int STRB_W = `CA_AXI_DATA_WIDTH / 8;

  logic       head_v;
  cache_tag_t head_tag;
  logic       head_pop;

  logic       pk_v_li;
  logic       pk_ready_lo;
  logic       beat_done;
  logic       word_done;

  word_cnt_t  word_cnt_q;
  beat_cnt_t  beat_cnt_q;

  // address channel, offer passes straight through
  assign yumi_o        = v_i && axi_awready_i;
  assign axi_awvalid_o = v_i;
  assign axi_awaddr_o  = axi_addr_i;
  assign axi_awid_o    = '0;
  assign axi_awlen_o   = 8'(`CA_AXI_BURST_LEN - 1);
  assign axi_awsize_o  = 3'($clog2(STRB_W));   // full-width beats
  assign axi_awburst_o = INCR;
  assign axi_awcache_o = 4'b0000;
  assign axi_awprot_o  = 3'b000;
  assign axi_awlock_o  = 1'b0;

  tag_fifo u_tag_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .v_i     (yumi_o),
    .data_i  (tag_i),
    .v_o     (head_v),
    .data_o  (head_tag),
    .yumi_i  (head_pop)
  );

  // only the head cache may feed the packer
  assign pk_v_li = head_v && dma_data_v_i[head_tag];

  always_comb begin
    dma_data_yumi_o           = '0;
    dma_data_yumi_o[head_tag] = pk_v_li && pk_ready_lo;
  end

  word_packer u_packer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .v_i     (pk_v_li),
    .data_i  (dma_data_i[head_tag]),
    .ready_o (pk_ready_lo),
    .v_o     (axi_wvalid_o),
    .data_o  (axi_wdata_o),
    .yumi_i  (beat_done)
  );

  assign axi_wstrb_o = {STRB_W{1'b1}};
  assign beat_done   = axi_wvalid_o && axi_wready_i;
  assign word_done   = pk_v_li && pk_ready_lo;

  // tag retires with the last word of its block
  assign head_pop = word_done && (word_cnt_q == word_cnt_t'(`CA_BLOCK_WORDS - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      word_cnt_q <= '0;
      beat_cnt_q <= '0;
    end else begin
      if (head_pop) begin
        word_cnt_q <= '0;
      end else if (word_done) begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
      if (beat_done && axi_wlast_o) begin
        beat_cnt_q <= '0;
      end else if (beat_done) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  assign axi_wlast_o = axi_wvalid_o
                    && (beat_cnt_q == beat_cnt_t'(`CA_AXI_BURST_LEN - 1));

  assign axi_bready_o = 1'b1;   // response dropped

endmodule

//--- src/tag_fifo.sv
// Granted tag queue
`timescale 1ns/1ps
`include "cache_axi_settings.svh"

module tag_fifo
  import cache_axi_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,

  input  logic       v_i,
  input  cache_tag_t data_i,

  output logic       v_o,
  output cache_tag_t data_o,
  input  logic       yumi_i
);

  localparam int DEPTH = `CA_NUM_CACHE;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  cache_tag_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // no ready: never more blocks in flight than caches
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (v_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (yumi_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (v_i && !yumi_i) begin
        count_q <= count_q + 1'b1;
      end else if (!v_i && yumi_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign v_o    = (count_q != '0);
  assign data_o = mem_q[rd_ptr_q];  // head

endmodule

//--- src/word_packer.sv
// DMA word to AXI beat packer
`timescale 1ns/1ps
`include "cache_axi_settings.svh"

module word_packer
  import cache_axi_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,

  input  logic      v_i,
  input  dma_word_t data_i,
  output logic      ready_o,

  output logic      v_o,
  output axi_beat_t data_o,
  input  logic      yumi_i
);

  localparam int WORD_W = `CA_DATA_WIDTH;
  localparam int RATIO  = `CA_AXI_DATA_WIDTH / `CA_DATA_WIDTH;
  localparam int FILL_W = $clog2(RATIO + 1);

  axi_beat_t         beat_q;
  logic [FILL_W-1:0] fill_q;   // words held in beat_q
  logic [FILL_W-1:0] wr_slot;
  logic              accept;

  assign v_o = (fill_q == FILL_W'(RATIO));

  // a full beat leaving frees every slot this same cycle
  assign ready_o = !v_o || yumi_i;
  assign accept  = v_i && ready_o;

  // after a drain the new word lands in slot 0
  assign wr_slot = yumi_i ? '0 : fill_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fill_q <= '0;
    end else begin
      if (yumi_i) begin
        fill_q <= accept ? FILL_W'(1) : '0;
      end else if (accept) begin
        fill_q <= fill_q + 1'b1;
      end
    end
  end

  // word k sits at bits k*WORD_W upward
  always_ff @(posedge clk_i) begin
    if (accept) begin
      beat_q[wr_slot*WORD_W +: WORD_W] <= data_i;
    end
  end

  assign data_o = beat_q;

endmodule

//--- src/writeback_arbiter.sv
// Round-robin write-back arbiter
`timescale 1ns/1ps
`include "cache_axi_settings.svh"

module writeback_arbiter
  import cache_axi_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  input  logic      [`CA_NUM_CACHE-1:0]        wb_v_i,
  input  axi_addr_t [`CA_NUM_CACHE-1:0]        wb_addr_i,
  output logic      [`CA_NUM_CACHE-1:0]        wb_yumi_o,

  output logic                                 req_v_o,
  output cache_tag_t                           req_tag_o,
  output axi_addr_t                            req_addr_o,
  input  logic                                 req_yumi_i
);

  arb_state_e state_q;
  cache_tag_t rr_ptr_q;   // highest priority index
  cache_tag_t sel_tag_q;
  axi_addr_t  sel_addr_q;

  cache_tag_t scan_idx;
  cache_tag_t pick_tag;
  logic       pick_found;
  cache_tag_t next_ptr;

  // first requester at or after the pointer
  always_comb begin
    pick_found = 1'b0;
    pick_tag   = rr_ptr_q;
    scan_idx   = rr_ptr_q;
    for (int i = 0; i < `CA_NUM_CACHE; i++) begin
      scan_idx = cache_tag_t'((int'(rr_ptr_q) + i) % `CA_NUM_CACHE);
      if (!pick_found && wb_v_i[scan_idx]) begin
        pick_found = 1'b1;
        pick_tag   = scan_idx;
      end
    end
  end

  assign next_ptr = cache_tag_t'((int'(sel_tag_q) + 1) % `CA_NUM_CACHE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ARB_IDLE;
      rr_ptr_q  <= '0;
      sel_tag_q <= '0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (pick_found) begin
            state_q   <= ARB_OFFER;
            sel_tag_q <= pick_tag;
          end
        end
        ARB_OFFER: begin
          if (req_yumi_i) begin   // aw accepted
            state_q  <= ARB_IDLE;
            rr_ptr_q <= next_ptr;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ARB_IDLE && pick_found) begin
      sel_addr_q <= wb_addr_i[pick_tag];
    end
  end

  assign req_v_o    = (state_q == ARB_OFFER);
  assign req_tag_o  = sel_tag_q;
  assign req_addr_o = sel_addr_q;

  // acceptance goes back to the chosen cache only
  always_comb begin
    wb_yumi_o            = '0;
    wb_yumi_o[sel_tag_q] = req_yumi_i;
  end

endmodule

//--- tb/tb_cache_axi_wb.sv
// Write-back path testbench
`timescale 1ns/1ps
`include "cache_axi_settings.svh"

module tb_cache_axi_wb
  import cache_axi_pkg::*;
();

  localparam int NC      = `CA_NUM_CACHE;
  localparam int N_ENT   = 12;
  localparam int BLK_W   = `CA_BLOCK_WORDS;
  localparam int BURST   = `CA_AXI_BURST_LEN;
  localparam int MAX_CYC = 5000;

  logic                        clk_i;
  logic                        rst_n_i;
  logic      [NC-1:0]          wb_v_i;
  axi_addr_t [NC-1:0]          wb_addr_i;
  logic      [NC-1:0]          wb_yumi_o;
  dma_word_t [NC-1:0]          dma_data_i;
  logic      [NC-1:0]          dma_data_v_i;
  logic      [NC-1:0]          dma_data_yumi_o;
  logic [`CA_AXI_ID_WIDTH-1:0] axi_awid_o;
  axi_addr_t                   axi_awaddr_o;
  logic [7:0]                  axi_awlen_o;
  logic [2:0]                  axi_awsize_o;
  axi_burst_e                  axi_awburst_o;
  logic [3:0]                  axi_awcache_o;
  logic [2:0]                  axi_awprot_o;
  logic                        axi_awlock_o;
  logic                        axi_awvalid_o;
  logic                        axi_awready_i;
  axi_beat_t                   axi_wdata_o;
  logic [`CA_AXI_DATA_WIDTH/8-1:0] axi_wstrb_o;
  logic                        axi_wlast_o;
  logic                        axi_wvalid_o;
  logic                        axi_wready_i;
  logic [`CA_AXI_ID_WIDTH-1:0] axi_bid_i;
  logic [1:0]                  axi_bresp_i;
  logic                        axi_bvalid_i;
  logic                        axi_bready_o;

  // write-back table of cache index, block address and launch cycle
  int        ent_cache  [N_ENT] = '{0, 1, 2, 3, 1, 3, 2, 0, 3, 1, 2, 0};
  axi_addr_t ent_addr   [N_ENT] = '{32'h1000_0000, 32'h2000_0100, 32'h3000_0200,
                                    32'h4000_0300, 32'h2000_0400, 32'h4000_0500,
                                    32'h3000_0600, 32'h1000_0700, 32'h4000_0800,
                                    32'h2000_0900, 32'h3000_0a00, 32'h1000_0b00};
  int        ent_launch [N_ENT] = '{3, 3, 3, 3, 6, 6, 7, 20, 20, 40, 40, 41};

  int        pend_q [NC][$];   // entry indices per cache
  int        exp_aw_q [$];
  axi_beat_t exp_beat_q [$];
  logic [NC-1:0] busy;         // cache streaming its block
  axi_addr_t cur_addr [NC];
  int        word_idx [NC];
  logic      arb_idle;
  int        rr_ptr;
  logic      any_req;
  int        cyc;
  int        aw_cnt;
  int        w_cnt;
  int        val_errs;
  int        other_errs;

  cache_axi_wb_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_addr(string name, axi_addr_t got, axi_addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_beat(string name, axi_beat_t got, axi_beat_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_burst(string name, axi_burst_e got, axi_burst_e exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_bits(string name, logic [15:0] got, logic [15:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  // first requester at or after ptr or -1 when none
  function automatic int rr_pick(logic [NC-1:0] req, int ptr);
    int idx;
    for (int k = 0; k < NC; k++) begin
      idx = (ptr + k) % NC;
      if (req[idx])
        return idx;
    end
    return -1;
  endfunction

  task automatic push_beats(axi_addr_t base);
    dma_word_t lo;
    dma_word_t hi;
    for (int b = 0; b < BURST; b++) begin
      lo = base + 4 * (2 * b);      // first word in the low half
      hi = base + 4 * (2 * b + 1);
      exp_beat_q.push_back({hi, lo});
    end
  endtask

  task automatic drive_inputs();
    for (int e = 0; e < N_ENT; e++) begin
      if (ent_launch[e] == cyc)
        pend_q[ent_cache[e]].push_back(e);
    end
    for (int i = 0; i < NC; i++) begin
      wb_v_i[i]       = !busy[i] && (pend_q[i].size() > 0);
      wb_addr_i[i]    = wb_v_i[i] ? ent_addr[pend_q[i][0]] : '0;
      dma_data_v_i[i] = busy[i] && ($urandom % 2 == 0);
      dma_data_i[i]   = cur_addr[i] + 4 * word_idx[i];
    end
    if (|wb_v_i)
      any_req = 1'b1;
    axi_awready_i = ($urandom % 4 != 0);
    axi_wready_i  = ($urandom % 3 != 0);
  endtask

  task automatic sample_outputs();
    int            e;
    int            pick;
    logic [NC-1:0] exp_yumi;
    exp_yumi = '0;
    if (!any_req)
      check_bits("reset outputs", 16'({axi_awvalid_o, axi_wvalid_o, wb_yumi_o,
                 dma_data_yumi_o}), '0);
    check_bits("axi_awvalid_o", 16'(axi_awvalid_o), 16'(!arb_idle));
    check_bits("axi_bready_o", 16'(axi_bready_o), 16'd1);
    if (axi_awvalid_o && axi_awready_i) begin
      if (exp_aw_q.size() == 0) begin
        $display("write address %h accepted with no grant pending", axi_awaddr_o);
        other_errs++;
      end else begin
        e = exp_aw_q.pop_front();
        check_addr("axi_awaddr_o", axi_awaddr_o, ent_addr[e]);
        check_bits("axi_awlen_o", 16'(axi_awlen_o), 16'(BURST - 1));
        check_bits("axi_awsize_o", 16'(axi_awsize_o), 16'd3);
        check_burst("axi_awburst_o", axi_awburst_o, INCR);
        check_bits("axi_awid_o", 16'(axi_awid_o), '0);
        check_bits("axi_awcache_o", 16'(axi_awcache_o), '0);
        check_bits("axi_awprot_o", 16'(axi_awprot_o), '0);
        check_bits("axi_awlock_o", 16'(axi_awlock_o), '0);
        exp_yumi[ent_cache[e]] = 1'b1;
        rr_ptr = (ent_cache[e] + 1) % NC;
        push_beats(ent_addr[e]);
        aw_cnt++;
      end
      arb_idle = 1'b1;
    end else if (arb_idle) begin
      pick = rr_pick(wb_v_i, rr_ptr);
      if (pick >= 0) begin
        exp_aw_q.push_back(pend_q[pick][0]);
        arb_idle = 1'b0;
      end
    end
    check_bits("wb_yumi_o", 16'(wb_yumi_o), 16'(exp_yumi));
    check_bits("dma_data_yumi_o", 16'(dma_data_yumi_o & ~dma_data_v_i), '0);
    for (int i = 0; i < NC; i++) begin
      if (dma_data_yumi_o[i] && !busy[i]) begin
        $display("cache %0d got a data yumi with no block granted", i);
        other_errs++;
      end else if (dma_data_yumi_o[i]) begin
        word_idx[i]++;
        if (word_idx[i] == BLK_W)
          busy[i] = 1'b0;
      end
      if (wb_yumi_o[i] && pend_q[i].size() > 0) begin
        e           = pend_q[i].pop_front();
        busy[i]     = 1'b1;
        cur_addr[i] = ent_addr[e];
        word_idx[i] = 0;
      end
    end
    if (axi_wvalid_o && axi_wready_i) begin
      if (exp_beat_q.size() == 0) begin
        $display("write beat accepted with no burst outstanding");
        other_errs++;
      end else begin
        check_beat("axi_wdata_o", axi_wdata_o, exp_beat_q.pop_front());
      end
      check_bits("axi_wstrb_o", 16'(axi_wstrb_o), 16'hff);
      check_bits("axi_wlast_o", 16'(axi_wlast_o), 16'(w_cnt % BURST == BURST - 1));
      w_cnt++;
    end
  endtask

  initial begin
    void'($urandom(26964));
    rst_n_i       = 1'b0;
    wb_v_i        = '0;
    wb_addr_i     = '0;
    dma_data_i    = '0;
    dma_data_v_i  = '0;
    axi_awready_i = 1'b0;
    axi_wready_i  = 1'b0;
    axi_bid_i     = '0;
    axi_bresp_i   = '0;
    axi_bvalid_i  = 1'b0;
    busy          = '0;
    arb_idle      = 1'b1;
    rr_ptr        = 0;
    any_req       = 1'b0;
    cyc           = 0;
    aw_cnt        = 0;
    w_cnt         = 0;
    val_errs      = 0;
    other_errs    = 0;
    for (int i = 0; i < NC; i++) begin
      cur_addr[i] = '0;
      word_idx[i] = 0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    while (w_cnt < N_ENT * BURST && cyc < MAX_CYC) begin
      drive_inputs();
      @(posedge clk_i);
      sample_outputs();
      @(negedge clk_i);
      cyc++;
    end
    if (cyc >= MAX_CYC) begin
      $display("timeout: only %0d of %0d write beats seen", w_cnt, N_ENT * BURST);
      other_errs++;
    end
    if (aw_cnt != N_ENT) begin
      $display("saw %0d write addresses but the table has %0d", aw_cnt, N_ENT);
      other_errs++;
    end
    $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
